/* tb.f */
+incdir+verif
src/exu_pkg.sv
src/exu_stage_in.sv
src/exu_alu.sv
src/exu_mul.sv
src/exu_branch_check.sv
src/exu_stage_out.sv
src/exu_top.sv
verif/exu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module exu_tb -f tb.f -o exu_sim
./obj_dir/exu_sim > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

/* verif/exu_ref.svh */
/*
 * Reference model of the execute stage for the testbench.
 * Include inside a module that imports exu_pkg. Works on a whole
 * decoded instruction and assumes a 64-bit datapath.
 */
`ifndef EXU_REF_SVH
`define EXU_REF_SVH

// Expected ALU result, product or compare outcome
function automatic logic [63:0] ref_alu(input ds_to_es_t i);
    logic [63:0]        a;
    logic [63:0]        b;
    logic [63:0]        r;
    logic [5:0]         sh;
    logic signed [31:0] w;
    case (i.src1_sel)
        PC:      a = {32'b0, i.pc};
        ZERO:    a = 64'b0;
        default: a = i.rs1_value;
    endcase
    case (i.src2_sel)
        IMM:     b = i.imm;
        FOUR:    b = 64'd4;
        SHAMT:   b = {58'b0, i.shamt};
        default: b = i.rs2_value;
    endcase
    // Word forms shift by five bits only
    sh = i.word_op ? {1'b0, b[4:0]} : b[5:0];
    w  = a[31:0];
    case (i.op)
        ADD:  r = a + b;
        SUB:  r = a - b;
        SLT:  r = {63'b0, $signed(a) < $signed(b)};
        SLTU: r = {63'b0, a < b};
        AND:  r = a & b;
        OR:   r = a | b;
        XOR:  r = a ^ b;
        SLL:  r = a << sh;
        SRL: begin
            if (i.word_op) begin
                r = {32'b0, a[31:0]} >> sh;
            end else begin
                r = a >> sh;
            end
        end
        SRA: begin
            if (i.word_op) begin
                r = {32'b0, w >>> sh};
            end else begin
                r = $signed(a) >>> sh;
            end
        end
        MUL:  r = a * b;
        BEQ:  r = {63'b0, a == b};
        BNE:  r = {63'b0, a != b};
        BLT:  r = {63'b0, $signed(a) < $signed(b)};
        BGE:  r = {63'b0, $signed(a) >= $signed(b)};
        BLTU: r = {63'b0, a < b};
        BGEU: r = {63'b0, a >= b};
        default: r = a + b;
    endcase
    if (i.word_op) begin
        r = {{32{r[31]}}, r[31:0]};
    end
    return r;
endfunction

// Real target of a branch or jalr
function automatic logic [PC_W-1:0] ref_target(input ds_to_es_t i);
    logic [PC_W-1:0] t;
    if (i.is_jalr) begin
        t    = i.rs1_value[31:0] + i.imm[31:0];
        t[0] = 1'b0;
    end else begin
        t = i.pc + i.imm[31:0];
    end
    return t;
endfunction

// Redirect flag, with the corrected PC through pc_o
function automatic logic ref_redirect(input ds_to_es_t i, output logic [PC_W-1:0] pc_o);
    logic [63:0]     cond;
    logic [PC_W-1:0] tgt;
    logic            taken;
    cond  = ref_alu(i);
    tgt   = ref_target(i);
    taken = i.is_jalr || (i.is_branch && cond[0]);
    pc_o  = taken ? tgt : i.pc + 32'd4;
    return (i.is_branch || i.is_jalr) &&
           (taken != i.br_taken_pre || (taken && tgt != i.br_target_pre));
endfunction

// Store byte enables, none for loads
function automatic logic [7:0] ref_wen(input ds_to_es_t i);
    logic [63:0] addr;
    logic [7:0]  base;
    logic [7:0]  w;
    addr = ref_alu(i);
    case (i.mem_size)
        BYTE:    base = 8'h01;
        HALF:    base = 8'h03;
        WORD:    base = 8'h0f;
        default: base = 8'hff;
    endcase
    w = base << addr[2:0];
    return i.mem_we ? w : 8'h00;
endfunction

`endif

/* verif/exu_tb.sv */
/*
 * Testbench for the execute stage top level.
 * Sends random decoded instructions, answers data-memory requests after
 * a random delay and checks every cycle against the reference model.
 */
`timescale 1ns/1ns

module exu_tb;
    import exu_pkg::*;

    `include "exu_ref.svh"

    localparam int XLEN    = 64;
    localparam int TIMEOUT = 400;
    localparam int N_INST  = 40;

    logic            clk = 1'b0;
    logic            reset;
    logic            ds_to_es_valid_i;
    ds_to_es_t       ds_to_es_i;
    logic            es_allowin_o;
    logic            ms_allowin_i = 1'b1;
    logic            es_to_ms_valid_o;
    es_to_ms_t       es_to_ms_o;
    es_forward_t     es_forward_o;
    logic            mem_req_o;
    logic            mem_ready_i = 1'b0;
    logic [XLEN-1:0] mem_addr_o;
    logic [7:0]      mem_wen_o;
    logic [XLEN-1:0] mem_wdata_o;
    logic            redirect_o;
    logic [PC_W-1:0] redirect_pc_o;

    int        seed = 32'h02b0_8c97;
    int        errors = 0;
    int        checks = 0;
    int        done_count = 0;
    logic      stall_mode = 1'b0;
    logic      timed_out = 1'b0;
    logic      mem_seen = 1'b0;
    logic      held = 1'b0;
    es_to_ms_t held_bus;
    ds_to_es_t exp_q[$];

    exu_top #(.XLEN(XLEN)) dut (
        .clk              (clk),
        .reset            (reset),
        .ds_to_es_valid_i (ds_to_es_valid_i),
        .ds_to_es_i       (ds_to_es_i),
        .es_allowin_o     (es_allowin_o),
        .ms_allowin_i     (ms_allowin_i),
        .es_to_ms_valid_o (es_to_ms_valid_o),
        .es_to_ms_o       (es_to_ms_o),
        .es_forward_o     (es_forward_o),
        .mem_req_o        (mem_req_o),
        .mem_ready_i      (mem_ready_i),
        .mem_addr_o       (mem_addr_o),
        .mem_wen_o        (mem_wen_o),
        .mem_wdata_o      (mem_wdata_o),
        .redirect_o       (redirect_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    always #20 clk = ~clk;

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    function automatic ds_to_es_t gen_inst(input int kind);
        ds_to_es_t  i;
        logic [11:0] r12;
        int          k;
        i           = '0;
        k           = (kind == 4) ? pick(4) : kind;
        r12         = 12'($random(seed));
        i.imm       = {{52{r12[11]}}, r12};
        i.rs1_value = {$random(seed), $random(seed)};
        i.rs2_value = {$random(seed), $random(seed)};
        i.shamt     = 6'($random(seed));
        i.pc        = 32'($random(seed)) & ~32'h3;
        i.rd        = 5'($random(seed));
        i.rf_we     = 1'b1;
        case (k)
            0: begin
                i.op       = alu_op_e'(pick(10));
                i.word_op  = (i.op inside {ADD, SUB, SLL, SRL, SRA}) && pick(2) != 0;
                i.src1_sel = src1_sel_e'(pick(3));
                if (i.op inside {SLL, SRL, SRA}) begin
                    i.src2_sel = (pick(2) != 0) ? SHAMT : RS2;
                end else begin
                    i.src2_sel = src2_sel_e'(pick(3));
                end
            end
            1: i.op = MUL;
            2: begin
                if (pick(2) != 0) begin
                    i.src1_sel = PC;
                    i.src2_sel = FOUR;
                    i.is_jalr  = 1'b1;
                end else begin
                    i.op        = alu_op_e'(11 + pick(6));
                    i.rf_we     = 1'b0;
                    i.is_branch = 1'b1;
                    if (pick(4) == 0) begin
                        i.rs2_value = i.rs1_value;
                    end
                end
                i.br_taken_pre  = pick(2) != 0;
                i.br_target_pre = (pick(2) != 0) ? ref_target(i) : 32'($random(seed)) & ~32'h3;
            end
            default: begin
                i.src2_sel  = IMM;
                i.mem_size  = mem_size_e'(pick(4));
                i.mem_we    = pick(2) != 0;
                i.mem_re    = !i.mem_we;
                i.rf_we     = i.mem_re;
                i.load_sext = pick(2) != 0;
            end
        endcase
        return i;
    endfunction

    task automatic send(input ds_to_es_t inst);
        int   t;
        logic taken;
        if (timed_out) begin
            return;
        end
        ds_to_es_valid_i <= 1'b1;
        ds_to_es_i       <= inst;
        t = 0;
        do begin
            @(posedge clk);
            taken = es_allowin_o;
            t++;
        end while (!taken && t < TIMEOUT);
        if (!taken) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout: instruction at pc %h was not accepted by the stage", inst.pc);
        end
    endtask

    task automatic drain();
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (exp_q.size() != 0 && t < TIMEOUT && !timed_out);
        if (exp_q.size() != 0 && !timed_out) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout: the stage did not hand its last instruction to memory");
        end
        @(posedge clk);
    endtask

    task automatic run_test(input string name, input int kind, input logic stall);
        int err0;
        int done0;
        err0        = errors;
        done0       = done_count;
        stall_mode <= stall;
        for (int n = 0; n < N_INST; n++) begin
            send(gen_inst(kind));
            if (pick(4) == 0) begin
                ds_to_es_valid_i <= 1'b0;
                @(posedge clk);
            end
        end
        ds_to_es_valid_i <= 1'b0;
        drain();
        check(128'(done_count - done0), 128'(N_INST), "transfers per test");
        $display("test %s: %0d transfers, %0d errors", name, done_count - done0,
                 errors - err0);
    endtask

    // ------------------------------------------------------------------
    // Memory stage and data memory
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            ms_allowin_i <= 1'b1;
        end else begin
            ms_allowin_i <= !stall_mode || pick(3) != 0;
        end
    end

    // One-cycle ready after a random wait
    always @(posedge clk) begin
        if (reset || mem_ready_i) begin
            mem_ready_i <= 1'b0;
        end else begin
            mem_ready_i <= mem_req_o && pick(4) == 0;
        end
    end

    // ------------------------------------------------------------------
    // Compare against the item in the stage
    // ------------------------------------------------------------------
    always @(posedge clk) begin : compare
        ds_to_es_t       cur;
        logic            exp_redirect;
        logic [PC_W-1:0] exp_pc;
        logic            leave;
        if (!reset) begin
            leave = es_to_ms_valid_o && ms_allowin_i;
            if (held) begin
                check(128'(es_to_ms_valid_o), 128'(1), "held item still valid");
                check(128'(es_to_ms_o), 128'(held_bus), "held es_to_ms_o stable");
            end
            if (exp_q.size() == 0) begin
                check(128'(es_to_ms_valid_o), 128'(0), "es_to_ms_valid_o with empty stage");
                check(128'(redirect_o), 128'(0), "redirect_o with empty stage");
                check(128'(mem_req_o), 128'(0), "mem_req_o with empty stage");
                check(128'(es_forward_o.valid), 128'(0), "forward valid with empty stage");
            end else begin
                cur          = exp_q[0];
                exp_redirect = ref_redirect(cur, exp_pc);
                check(128'(redirect_o), 128'(exp_redirect), "redirect_o");
                if (exp_redirect) begin
                    check(128'(redirect_pc_o), 128'(exp_pc), "redirect_pc_o");
                end
                check(128'(es_forward_o.valid), 128'(cur.rf_we), "forward valid");
                check(128'(es_forward_o.load_pending), 128'(cur.mem_re), "load_pending");
                if (cur.rf_we) begin
                    check(128'(es_forward_o.rd), 128'(cur.rd), "forward rd");
                end
                if (cur.rf_we && !cur.mem_re && cur.op != MUL) begin
                    check(128'(es_forward_o.value), 128'(ref_alu(cur)), "forward value");
                end
                if (cur.mem_re || cur.mem_we) begin
                    check(128'(mem_req_o), 128'(!mem_seen), "mem_req_o level");
                    if (mem_req_o) begin
                        check(128'(mem_addr_o), 128'(ref_alu(cur)), "mem_addr_o");
                        check(128'(mem_wen_o), 128'(ref_wen(cur)), "mem_wen_o");
                        check(128'(mem_wdata_o), 128'(cur.rs2_value), "mem_wdata_o");
                    end else begin
                        check(128'(mem_wen_o), 128'(0), "mem_wen_o without request");
                    end
                    if (mem_req_o && mem_ready_i) begin
                        mem_seen = 1'b1;
                    end
                end else begin
                    check(128'(mem_req_o), 128'(0), "mem_req_o without access");
                end
                if (!cur.mem_re && !cur.mem_we && cur.op != MUL) begin
                    check(128'(es_to_ms_valid_o), 128'(1), "single-cycle result ready");
                end
                if (cur.op == MUL && !leave) begin
                    check(128'(es_allowin_o), 128'(0), "es_allowin_o during MUL");
                end
                if (leave) begin
                    check(128'(es_to_ms_o.result), 128'(ref_alu(cur)), "es_to_ms result");
                    check(128'(es_to_ms_o.rd), 128'(cur.rd), "es_to_ms rd");
                    check(128'(es_to_ms_o.rf_we), 128'(cur.rf_we), "es_to_ms rf_we");
                    check(128'(es_to_ms_o.pc), 128'(cur.pc), "es_to_ms pc");
                    check(128'(es_to_ms_o.mem_re), 128'(cur.mem_re), "es_to_ms mem_re");
                    check(128'(es_to_ms_o.mem_size), 128'(cur.mem_size), "mem_size");
                    check(128'(es_to_ms_o.load_sext), 128'(cur.load_sext), "load_sext");
                    void'(exp_q.pop_front());
                    done_count++;
                    mem_seen = 1'b0;
                end
            end
            held     = es_to_ms_valid_o && !ms_allowin_i;
            held_bus = es_to_ms_o;
            if (ds_to_es_valid_i && es_allowin_o) begin
                exp_q.push_back(ds_to_es_i);
            end
        end
    end

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        reset            = 1'b1;
        ds_to_es_valid_i = 1'b0;
        ds_to_es_i       = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        run_test("alu", 0, 1'b0);
        run_test("mul", 1, 1'b0);
        run_test("branch", 2, 1'b0);
        run_test("memory", 3, 1'b0);
        run_test("stall", 4, 1'b1);
        finish_run();
    end

endmodule

/* src/exu_top.sv */
/*
 * Execute stage top level.
 * Connects the input side, ALU, multiplier, branch check and output
 * side; XLEN is set here and passed down.
 */
`timescale 1ns/1ns

module exu_top #(
    parameter int XLEN = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ds_to_es_valid_i,
    input  exu_pkg::ds_to_es_t       ds_to_es_i,
    output logic                     es_allowin_o,
    input  logic                     ms_allowin_i,
    output logic                     es_to_ms_valid_o,
    output exu_pkg::es_to_ms_t       es_to_ms_o,
    output exu_pkg::es_forward_t     es_forward_o,
    output logic                     mem_req_o,
    input  logic                     mem_ready_i,
    output logic [XLEN-1:0]          mem_addr_o,
    output logic [7:0]               mem_wen_o,
    output logic [XLEN-1:0]          mem_wdata_o,
    output logic                     redirect_o,
    output logic [exu_pkg::PC_W-1:0] redirect_pc_o
);
    import exu_pkg::*;

    logic            es_valid;
    ds_to_es_t       inst;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mul_product;
    logic            mul_start;
    logic            mul_busy;
    logic            mul_done;
    logic            mem_stall;

    // Drop start as the finished product leaves, so a following MUL restarts
    assign mul_start = es_valid && inst.op == MUL && !(mul_done && ms_allowin_i);

    exu_stage_in #(.XLEN(XLEN)) u_stage_in (
        .clk              (clk),
        .reset            (reset),
        .ds_to_es_valid_i (ds_to_es_valid_i),
        .ds_to_es_i       (ds_to_es_i),
        .ms_allowin_i     (ms_allowin_i),
        .mul_busy_i       (mul_busy),
        .mem_stall_i      (mem_stall),
        .es_allowin_o     (es_allowin_o),
        .es_valid_o       (es_valid),
        .es_to_ms_valid_o (es_to_ms_valid_o),
        .inst_o           (inst),
        .src1_o           (src1),
        .src2_o           (src2)
    );

    exu_alu #(.XLEN(XLEN)) u_alu (
        .op_i      (inst.op),
        .word_op_i (inst.word_op),
        .src1_i    (src1),
        .src2_i    (src2),
        .result_o  (alu_result)
    );

    exu_mul #(.XLEN(XLEN)) u_mul (
        .clk       (clk),
        .reset     (reset),
        .start_i   (mul_start),
        .a_i       (src1),
        .b_i       (src2),
        .busy_o    (mul_busy),
        .done_o    (mul_done),
        .product_o (mul_product)
    );

    exu_branch_check #(.XLEN(XLEN)) u_branch_check (
        .valid_i       (es_valid),
        .is_branch_i   (inst.is_branch),
        .is_jalr_i     (inst.is_jalr),
        .cond_i        (alu_result[0]),
        .pc_i          (inst.pc),
        .imm_i         (inst.imm[XLEN-1:0]),
        .rs1_i         (inst.rs1_value[XLEN-1:0]),
        .taken_pre_i   (inst.br_taken_pre),
        .target_pre_i  (inst.br_target_pre),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    exu_stage_out #(.XLEN(XLEN)) u_stage_out (
        .clk           (clk),
        .reset         (reset),
        .es_valid_i    (es_valid),
        .inst_i        (inst),
        .alu_result_i  (alu_result),
        .mul_product_i (mul_product),
        .ms_allowin_i  (ms_allowin_i),
        .mem_ready_i   (mem_ready_i),
        .mem_stall_o   (mem_stall),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wen_o     (mem_wen_o),
        .mem_wdata_o   (mem_wdata_o),
        .es_to_ms_o    (es_to_ms_o),
        .es_forward_o  (es_forward_o)
    );

endmodule

/* src/exu_stage_out.sv */
/*
 * Output side of the execute stage.
 * Picks the result, runs the data-memory request with byte enables and
 * builds the memory-stage and forwarding buses.
 */
`timescale 1ns/1ns

module exu_stage_out #(
    parameter int XLEN = 64
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                es_valid_i,
    input  exu_pkg::ds_to_es_t  inst_i,
    input  logic [XLEN-1:0]     alu_result_i,
    input  logic [XLEN-1:0]     mul_product_i,
    input  logic                ms_allowin_i,
    input  logic                mem_ready_i,
    output logic                mem_stall_o,
    output logic                mem_req_o,
    output logic [XLEN-1:0]     mem_addr_o,
    output logic [7:0]          mem_wen_o,
    output logic [XLEN-1:0]     mem_wdata_o,
    output exu_pkg::es_to_ms_t  es_to_ms_o,
    output exu_pkg::es_forward_t es_forward_o
);
    import exu_pkg::*;

    logic            mem_done_q;
    logic            leave;
    logic [7:0]      wen_base;
    logic [XLEN-1:0] result;

    // ------------------------------------------------------------------
    // Data memory request
    // ------------------------------------------------------------------
    assign mem_req_o   = es_valid_i && (inst_i.mem_re || inst_i.mem_we) && !mem_done_q;
    assign mem_stall_o = mem_req_o && !mem_ready_i;
    assign leave       = es_valid_i && ms_allowin_i && !mem_stall_o;

    // Access finished, keep the request down until the item moves on
    always_ff @(posedge clk) begin
        if (reset || leave) begin
            mem_done_q <= 1'b0;
        end else if (mem_req_o && mem_ready_i) begin
            mem_done_q <= 1'b1;
        end
    end

    always_comb begin
        case (inst_i.mem_size)
            BYTE:    wen_base = 8'h01;
            HALF:    wen_base = 8'h03;
            WORD:    wen_base = 8'h0f;
            default: wen_base = 8'hff;
        endcase
    end

    assign mem_addr_o  = alu_result_i;
    assign mem_wdata_o = inst_i.rs2_value[XLEN-1:0];
    assign mem_wen_o   = (mem_req_o && inst_i.mem_we) ? wen_base << alu_result_i[2:0] : 8'h00;

    // ------------------------------------------------------------------
    // Result buses
    // ------------------------------------------------------------------
    assign result = (inst_i.op == MUL) ? mul_product_i : alu_result_i;

    assign es_to_ms_o = '{
        result:    64'(result),
        pc:        inst_i.pc,
        rd:        inst_i.rd,
        rf_we:     inst_i.rf_we,
        mem_re:    inst_i.mem_re,
        mem_size:  inst_i.mem_size,
        load_sext: inst_i.load_sext
    };

    assign es_forward_o = '{
        valid:        es_valid_i && inst_i.rf_we,
        load_pending: es_valid_i && inst_i.mem_re,
        rd:           inst_i.rd,
        value:        64'(result)
    };

    a_req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req_o && !mem_ready_i |=> mem_req_o && $stable(mem_addr_o));

endmodule

/* src/exu_branch_check.sv */
/*
 * Branch and jalr resolution.
 * Computes the real target and outcome and flags a redirect when the
 * prediction from fetch was wrong.
 */
`timescale 1ns/1ns

module exu_branch_check #(
    parameter int XLEN = 64
) (
    input  logic                     valid_i,
    input  logic                     is_branch_i,
    input  logic                     is_jalr_i,
    input  logic                     cond_i,
    input  logic [exu_pkg::PC_W-1:0] pc_i,
    input  logic [XLEN-1:0]          imm_i,
    input  logic [XLEN-1:0]          rs1_i,
    input  logic                     taken_pre_i,
    input  logic [exu_pkg::PC_W-1:0] target_pre_i,
    output logic                     redirect_o,
    output logic [exu_pkg::PC_W-1:0] redirect_pc_o
);
    import exu_pkg::*;

    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sum;
    logic [PC_W-1:0] target;
    logic            taken;
    logic            mismatch;

    assign base   = is_jalr_i ? rs1_i : XLEN'(pc_i);
    assign sum    = base + imm_i;
    // jalr clears bit 0 of the computed address
    assign target = {sum[PC_W-1:1], sum[0] & !is_jalr_i};

    assign taken    = is_jalr_i || (is_branch_i && cond_i);
    assign mismatch = (taken != taken_pre_i) || (taken && target != target_pre_i);

    assign redirect_o    = valid_i && (is_branch_i || is_jalr_i) && mismatch;
    assign redirect_pc_o = taken ? target : pc_i + PC_W'(4);

endmodule

/* src/exu_mul.sv */
/*
 * Iterative shift-add multiplier.
 * Loads its operands when start_i rises, runs XLEN add/shift steps and
 * holds the low XLEN bits of the product until start_i drops.
 */
`timescale 1ns/1ns

module exu_mul #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic            busy_o,
    output logic            done_o,
    output logic [XLEN-1:0] product_o
);
    localparam int CNT_W = $clog2(XLEN);

    logic             run_q;
    logic             done_q;
    logic [CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]  mcand_q;
    logic [XLEN-1:0]  mplier_q;
    logic [XLEN-1:0]  acc_q;
    logic             load;

    assign load = start_i && !run_q && !done_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q  <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (!start_i) begin
            run_q  <= 1'b0;
            done_q <= 1'b0;
        end else if (load) begin
            run_q <= 1'b1;
            cnt_q <= '0;
        end else if (run_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(XLEN - 1)) begin
                run_q  <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // Datapath, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (load) begin
            mcand_q  <= a_i;
            mplier_q <= b_i;
            acc_q    <= '0;
        end else if (run_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign busy_o    = start_i && !done_q;
    assign done_o    = done_q;
    assign product_o = acc_q;

    // Product is ready one load cycle plus XLEN steps after the start
    a_done_latency: assert property (@(posedge clk) disable iff (reset)
        $rose(done_o) |-> $past(load, XLEN + 1));

endmodule

/* src/exu_alu.sv */
/*
 * Single-cycle integer ALU.
 * Compare ops return the condition in bit 0; word ops sign-extend
 * the low 32 bits of the result.
 */
`timescale 1ns/1ns

module exu_alu #(
    parameter int XLEN = 64
) (
    input  exu_pkg::alu_op_e op_i,
    input  logic             word_op_i,
    input  logic [XLEN-1:0]  src1_i,
    input  logic [XLEN-1:0]  src2_i,
    output logic [XLEN-1:0]  result_o
);
    import exu_pkg::*;

    localparam int SH_W = $clog2(XLEN);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] res;
    logic [SH_W-1:0] sh;
    logic [31:0]     sraw;
    logic            eq;
    logic            lt;
    logic            ltu;

    assign sum  = src1_i + src2_i;
    assign diff = src1_i - src2_i;
    assign sh   = src2_i[SH_W-1:0];
    assign eq   = src1_i == src2_i;
    assign lt   = $signed(src1_i) < $signed(src2_i);
    assign ltu  = src1_i < src2_i;

    // sraw must shift in bit 31, not the upper word
    assign sraw = $signed(src1_i[31:0]) >>> src2_i[4:0];

    always_comb begin
        case (op_i)
            ADD:  res = sum;
            SUB:  res = diff;
            SLT:  res = XLEN'(lt);
            SLTU: res = XLEN'(ltu);
            AND:  res = src1_i & src2_i;
            OR:   res = src1_i | src2_i;
            XOR:  res = src1_i ^ src2_i;
            SLL:  res = src1_i << sh;
            SRL:  res = src1_i >> sh;
            SRA: begin
                if (word_op_i) begin
                    res = XLEN'(sraw);
                end else begin
                    res = $signed(src1_i) >>> sh;
                end
            end
            BEQ:  res = XLEN'(eq);
            BNE:  res = XLEN'(!eq);
            BLT:  res = XLEN'(lt);
            BGE:  res = XLEN'(!lt);
            BLTU: res = XLEN'(ltu);
            BGEU: res = XLEN'(!ltu);
            // MUL product comes from the multiplier
            default: res = sum;
        endcase
    end

    assign result_o = word_op_i ? XLEN'(signed'(res[31:0])) : res;

endmodule

/* src/exu_stage_in.sv */
/*
 * Input side of the execute stage.
 * Registers one decoded instruction under the valid/allowin handshake
 * and selects the two ALU operands from the registered fields.
 */
`timescale 1ns/1ns

module exu_stage_in #(
    parameter int XLEN = 64
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              ds_to_es_valid_i,
    input  exu_pkg::ds_to_es_t ds_to_es_i,
    input  logic              ms_allowin_i,
    input  logic              mul_busy_i,
    input  logic              mem_stall_i,
    output logic              es_allowin_o,
    output logic              es_valid_o,
    output logic              es_to_ms_valid_o,
    output exu_pkg::ds_to_es_t inst_o,
    output logic [XLEN-1:0]   src1_o,
    output logic [XLEN-1:0]   src2_o
);
    import exu_pkg::*;

    localparam int SH_W = $clog2(XLEN);

    logic      es_valid;
    logic      ready_go;
    ds_to_es_t inst_q;
    logic      shift_op;
    logic      word_shift;

    // ------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------
    assign ready_go         = !mul_busy_i && !mem_stall_i;
    assign es_allowin_o     = !es_valid || (ready_go && ms_allowin_i);
    assign es_to_ms_valid_o = es_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin_o) begin
            es_valid <= ds_to_es_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid_i && es_allowin_o) begin
            inst_q <= ds_to_es_i;
        end
    end

    assign es_valid_o = es_valid;
    assign inst_o     = inst_q;

    // ------------------------------------------------------------------
    // Operand select
    // ------------------------------------------------------------------
    assign shift_op   = inst_q.op inside {SLL, SRL, SRA};
    assign word_shift = shift_op && inst_q.word_op;

    always_comb begin
        case (inst_q.src1_sel)
            PC:      src1_o = XLEN'(inst_q.pc);
            ZERO:    src1_o = '0;
            default: begin
                // sllw/srlw/sraw only look at the low word
                if (word_shift) begin
                    src1_o = XLEN'(inst_q.rs1_value[31:0]);
                end else begin
                    src1_o = inst_q.rs1_value[XLEN-1:0];
                end
            end
        endcase
    end

    always_comb begin
        case (inst_q.src2_sel)
            IMM:   src2_o = inst_q.imm[XLEN-1:0];
            FOUR:  src2_o = XLEN'(4);
            SHAMT: begin
                if (inst_q.word_op) begin
                    src2_o = XLEN'(inst_q.shamt[4:0]);
                end else begin
                    src2_o = XLEN'(inst_q.shamt[SH_W-1:0]);
                end
            end
            default: begin
                if (word_shift) begin
                    src2_o = XLEN'(inst_q.rs2_value[4:0]);
                end else if (shift_op) begin
                    src2_o = XLEN'(inst_q.rs2_value[SH_W-1:0]);
                end else begin
                    src2_o = inst_q.rs2_value[XLEN-1:0];
                end
            end
        endcase
    end

    // Offered item stays valid and unchanged under back-pressure
    a_inst_hold: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid_o && !ms_allowin_i |=> es_to_ms_valid_o && $stable(inst_q));

endmodule

/* src/exu_pkg.sv */
/*
 * Shared types for the RV64 execute stage.
 * Holds the operation and operand-select encodings and the packed
 * buses exchanged with decode and the memory stage.
 */
package exu_pkg;

    localparam int PC_W = 32;

    typedef enum logic [4:0] {
        ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA, MUL,
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } alu_op_e;

    typedef enum logic [1:0] {
        BYTE, HALF, WORD, DOUBLE
    } mem_size_e;

    typedef enum logic [1:0] {
        RS1, PC, ZERO
    } src1_sel_e;

    typedef enum logic [2:0] {
        RS2, IMM, FOUR, SHAMT
    } src2_sel_e;

    // ------------------------------------------------------------------
    // Stage buses
    // ------------------------------------------------------------------
    typedef struct packed {
        alu_op_e             op;
        src1_sel_e           src1_sel;
        src2_sel_e           src2_sel;
        logic                word_op;
        logic [63:0]         imm;
        logic [5:0]          shamt;
        logic [63:0]         rs1_value;
        logic [63:0]         rs2_value;
        logic [PC_W-1:0]     pc;
        logic [4:0]          rd;
        logic                rf_we;
        logic                mem_re;
        logic                mem_we;
        mem_size_e           mem_size;
        logic                load_sext;   // signed load (lb/lh/lw)
        logic                is_branch;
        logic                is_jalr;
        logic                br_taken_pre;
        logic [PC_W-1:0]     br_target_pre;
    } ds_to_es_t;

    typedef struct packed {
        logic [63:0]         result;
        logic [PC_W-1:0]     pc;
        logic [4:0]          rd;
        logic                rf_we;
        logic                mem_re;
        mem_size_e           mem_size;
        logic                load_sext;
    } es_to_ms_t;

    // Bypass info back to decode
    typedef struct packed {
        logic                valid;
        logic                load_pending;
        logic [4:0]          rd;
        logic [63:0]         value;
    } es_forward_t;

endpackage
